//--- verilog/cmo_pkg.sv
// Cache maintenance operation handler package
// Cache geometry, operation encoding and the structs shared by the
// controller, the directory walker and the flush request queue
`default_nettype none

package cmo_pkg;

    // Cache geometry
    localparam int unsigned CMO_ADDR_W   = 32;
    localparam int unsigned CMO_OFFSET_W = 6;
    localparam int unsigned CMO_SET_W    = 6;
    localparam int unsigned CMO_TAG_W    = CMO_ADDR_W - CMO_OFFSET_W - CMO_SET_W;
    localparam int unsigned CMO_NLINE_W  = CMO_TAG_W + CMO_SET_W;
    localparam int unsigned CMO_WAYS     = 4;

    typedef logic [CMO_ADDR_W-1:0]  cmo_addr_t;
    typedef logic [CMO_SET_W-1:0]   cmo_set_t;
    typedef logic [CMO_TAG_W-1:0]   cmo_tag_t;
    typedef logic [CMO_NLINE_W-1:0] cmo_nline_t;
    typedef logic [CMO_WAYS-1:0]    cmo_way_vec_t;

    typedef enum logic [2:0] {
        CMO_FENCE,
        CMO_INVAL_NLINE,
        CMO_INVAL_ALL,
        CMO_FLUSH_ALL,
        CMO_FLUSH_INVAL_ALL
    } cmo_op_e;

    typedef struct packed {
        cmo_op_e   op;
        cmo_addr_t addr;
    } cmo_req_t;

    // Emptiness levels of the surrounding cache blocks
    typedef struct packed {
        logic wbuf_empty;
        logic mshr_empty;
        logic rtab_empty;
        logic ctrl_empty;
        logic flush_empty;
    } cmo_status_t;

    typedef struct packed {
        logic     valid;
        logic     dirty;
        cmo_tag_t tag;
    } dir_entry_rsp_t;

    // Also used to select a single entry, with a one-hot way
    typedef struct packed {
        cmo_set_t     set;
        cmo_way_vec_t way;
    } dir_inval_t;

    typedef struct packed {
        cmo_nline_t   nline;
        cmo_way_vec_t way;
    } flush_req_t;

endpackage

`default_nettype wire

//--- verilog/cmo_set_way_walker.sv
// Directory walker
// Set counter and one-hot way pointer that step through every entry,
// way by way within a set, and flag the last set and the last way
`timescale 1ns/100ps
`default_nettype none

module cmo_set_way_walker
    import cmo_pkg::*;
#(
    parameter int unsigned NumSets = 64
) (
    input  wire logic    clk_i,
    input  wire logic    rst_ni,
    input  wire logic    reset_i,
    input  wire logic    step_set_i,
    input  wire logic    step_way_i,
    output cmo_set_t     set_o,
    output cmo_way_vec_t way_o,
    output logic         set_last_o,
    output logic         way_last_o
);

    localparam cmo_set_t LastSet = cmo_set_t'(NumSets - 1);

    logic set_advance;

    assign set_last_o = (set_o == LastSet);
    assign way_last_o = way_o[CMO_WAYS-1];

    // Leaving the top way moves on to the next set
    assign set_advance = step_set_i | (step_way_i & way_last_o);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_o <= '0;
            way_o <= cmo_way_vec_t'(1);
        end else if (reset_i) begin
            set_o <= '0;
            way_o <= cmo_way_vec_t'(1);
        end else begin
            if (set_advance) begin
                set_o <= set_last_o ? '0 : set_o + 1'b1;
            end
            if (step_way_i) begin
                way_o <= way_last_o ? cmo_way_vec_t'(1) : {way_o[CMO_WAYS-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cmo_flush_fifo.sv
// Flush request queue
// Register FIFO for pending write-back requests, with feedthrough so that
// a request reaches the flush controller in the cycle it is written when
// the queue is empty
`timescale 1ns/100ps
`default_nettype none

module cmo_flush_fifo
    import cmo_pkg::*;
#(
    parameter int unsigned FlushFifoDepth = 3
) (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire logic       w_i,
    output logic            wok_o,
    input  wire flush_req_t wdata_i,
    input  wire logic       r_i,
    output logic            rok_o,
    output flush_req_t      rdata_o
);

    localparam int unsigned PtrW = (FlushFifoDepth > 1) ? $clog2(FlushFifoDepth) : 1;
    localparam int unsigned CntW = $clog2(FlushFifoDepth + 1);

    flush_req_t      mem_q [FlushFifoDepth];
    logic [PtrW-1:0] wptr_q;
    logic [PtrW-1:0] rptr_q;
    logic [CntW-1:0] count_q;

    logic empty;
    logic full;
    logic bypass;
    logic push;
    logic pop;

    function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
        next_ptr = (ptr == PtrW'(FlushFifoDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count_q == '0);
    assign full  = (count_q == CntW'(FlushFifoDepth));

    // One slot stays free for the write of a check already in flight
    assign wok_o = (count_q < CntW'(FlushFifoDepth - 1));

    assign rok_o   = ~empty | w_i;
    assign rdata_o = empty ? wdata_i : mem_q[rptr_q];

    // Written and read in the same cycle while empty, never stored
    assign bypass = empty & w_i & r_i;
    assign push   = w_i & ~full & ~bypass;
    assign pop    = r_i & ~empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= next_ptr(wptr_q);
            end
            if (pop) begin
                rptr_q <= next_ptr(rptr_q);
            end
            count_q <= count_q + CntW'(push) - CntW'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cmo_ctrl_fsm.sv
// Cache maintenance operation controller
// Decodes requests, waits for the cache to drain, issues directory line
// and entry checks and invalidations, and turns valid dirty entries found
// during flush walks into write-back requests
`timescale 1ns/100ps
`default_nettype none

module cmo_ctrl_fsm
    import cmo_pkg::*;
#(
    parameter int unsigned NumSets = 64
) (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,

    input  wire logic           req_valid_i,
    input  wire cmo_req_t       req_i,
    input  wire cmo_status_t    status_i,
    input  wire cmo_way_vec_t   dir_nline_hit_way_i,
    input  wire dir_entry_rsp_t dir_entry_rsp_i,

    input  wire cmo_set_t       set_i,
    input  wire cmo_way_vec_t   way_i,
    input  wire logic           set_last_i,
    input  wire logic           way_last_i,

    input  wire logic           fifo_wok_i,
    input  wire logic           fifo_rok_i,

    output logic                req_ready_o,
    output logic                req_wait_o,
    output logic                wbuf_flush_all_o,
    output logic                dir_check_nline_o,
    output cmo_nline_t          dir_check_nline_o_set_tag_o,
    output logic                dir_check_entry_o,
    output dir_inval_t          dir_entry_sel_o,
    output logic                dir_inval_o,
    output dir_inval_t          dir_inval_sel_o,
    output logic                walk_reset_o,
    output logic [1:0]          walk_step_o,
    output logic                fifo_w_o,
    output flush_req_t          fifo_wdata_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FENCE_WAIT,
        ST_DRAIN_WAIT,
        ST_LINE_CHECK,
        ST_INVAL_SET,
        ST_FLUSH_FIRST,
        ST_FLUSH_NEXT,
        ST_FLUSH_LAST
    } state_e;

    state_e       state_q, state_d;
    cmo_op_e      op_q, op_d;
    cmo_addr_t    addr_q, addr_d;

    // Entry checked in the previous cycle, evaluated on its response
    logic         pend_valid_q, pend_valid_d;
    logic         pend_inval_q, pend_inval_d;
    cmo_set_t     pend_set_q, pend_set_d;
    cmo_way_vec_t pend_way_q, pend_way_d;

    cmo_set_t     line_set;
    logic         line_in_range;
    logic         drained;
    logic         issue_check;

    function automatic state_e start_state(cmo_op_e op);
        case (op)
            CMO_INVAL_NLINE: start_state = ST_LINE_CHECK;
            CMO_INVAL_ALL:   start_state = ST_INVAL_SET;
            default:         start_state = ST_FLUSH_FIRST;
        endcase
    endfunction

    assign line_set = addr_q[CMO_OFFSET_W +: CMO_SET_W];
    // Lines mapping above the implemented sets cannot be cached
    assign line_in_range = (line_set <= cmo_set_t'(NumSets - 1));
    assign drained = status_i.mshr_empty & status_i.rtab_empty & status_i.ctrl_empty;

    assign req_ready_o = (state_q == ST_IDLE);
    assign req_wait_o  = (state_q == ST_FENCE_WAIT) || (state_q == ST_DRAIN_WAIT);

    assign dir_check_nline_o_set_tag_o = addr_q[CMO_OFFSET_W +: CMO_NLINE_W];
    assign dir_entry_sel_o = '{set: set_i, way: way_i};

    // Write-back request for a valid dirty entry in its response cycle
    assign fifo_w_o = pend_valid_q & dir_entry_rsp_i.valid & dir_entry_rsp_i.dirty;
    assign fifo_wdata_o = '{nline: {dir_entry_rsp_i.tag, pend_set_q}, way: pend_way_q};

    always_comb begin
        state_d      = state_q;
        op_d         = op_q;
        addr_d       = addr_q;
        pend_valid_d = pend_valid_q;
        pend_inval_d = pend_inval_q;
        pend_set_d   = pend_set_q;
        pend_way_d   = pend_way_q;

        issue_check       = 1'b0;
        walk_reset_o      = 1'b0;
        walk_step_o       = 2'b00;
        wbuf_flush_all_o  = 1'b0;
        dir_check_nline_o = 1'b0;
        dir_check_entry_o = 1'b0;
        dir_inval_o       = 1'b0;
        dir_inval_sel_o   = '{set: set_i, way: '0};

        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    if (req_i.op == CMO_FENCE) begin
                        // Ask the write buffer to send its open entries
                        wbuf_flush_all_o = status_i.rtab_empty;
                        if (!status_i.rtab_empty || !status_i.wbuf_empty) begin
                            state_d = ST_FENCE_WAIT;
                        end
                    end else begin
                        op_d         = req_i.op;
                        addr_d       = req_i.addr;
                        pend_inval_d = (req_i.op == CMO_FLUSH_INVAL_ALL);
                        walk_reset_o = 1'b1;
                        state_d      = drained ? start_state(req_i.op) : ST_DRAIN_WAIT;
                    end
                end
            end
            ST_FENCE_WAIT: begin
                wbuf_flush_all_o = status_i.rtab_empty;
                if (status_i.wbuf_empty && status_i.rtab_empty) begin
                    state_d = ST_IDLE;
                end
            end
            ST_DRAIN_WAIT: begin
                if (drained) begin
                    state_d = start_state(op_q);
                end
            end
            ST_LINE_CHECK: begin
                dir_check_nline_o = line_in_range;
                state_d = ST_INVAL_SET;
            end
            ST_INVAL_SET: begin
                if (op_q == CMO_INVAL_NLINE) begin
                    dir_inval_o     = line_in_range & (|dir_nline_hit_way_i);
                    dir_inval_sel_o = '{set: line_set, way: dir_nline_hit_way_i};
                    state_d         = ST_IDLE;
                end else begin
                    // All ways of one set per cycle
                    dir_inval_o     = 1'b1;
                    dir_inval_sel_o = '{set: set_i, way: '1};
                    walk_step_o[1]  = 1'b1;
                    if (set_last_i) begin
                        state_d = ST_IDLE;
                    end
                end
            end
            ST_FLUSH_FIRST: begin
                if (fifo_wok_i) begin
                    issue_check = 1'b1;
                    state_d     = ST_FLUSH_NEXT;
                end
            end
            ST_FLUSH_NEXT: begin
                if (pend_valid_q) begin
                    dir_inval_o     = pend_inval_q;
                    dir_inval_sel_o = '{set: pend_set_q, way: pend_way_q};
                    pend_valid_d    = 1'b0;
                end
                // With invalidation the directory is busy this cycle
                if ((!pend_valid_q || !pend_inval_q) && fifo_wok_i) begin
                    issue_check = 1'b1;
                    if (set_last_i && way_last_i) begin
                        state_d = ST_FLUSH_LAST;
                    end
                end
            end
            ST_FLUSH_LAST: begin
                pend_valid_d = 1'b0;
                if (pend_valid_q) begin
                    dir_inval_o     = pend_inval_q;
                    dir_inval_sel_o = '{set: pend_set_q, way: pend_way_q};
                end
                // Done once every queued write-back has left the flush controller
                if (!fifo_rok_i && status_i.flush_empty) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase

        if (issue_check) begin
            dir_check_entry_o = 1'b1;
            walk_step_o[0]    = 1'b1;
            pend_valid_d      = 1'b1;
            pend_set_d        = set_i;
            pend_way_d        = way_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ST_IDLE;
            pend_valid_q <= 1'b0;
            pend_inval_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            pend_valid_q <= pend_valid_d;
            pend_inval_q <= pend_inval_d;
        end
    end

    always_ff @(posedge clk_i) begin
        op_q       <= op_d;
        addr_q     <= addr_d;
        pend_set_q <= pend_set_d;
        pend_way_q <= pend_way_d;
    end

endmodule

`default_nettype wire

//--- verilog/cmo_handler.sv
// Cache maintenance operation handler
// Accepts fence, invalidate and flush requests for a set-associative
// write-back data cache and sequences them over the directory, the
// write buffer and the flush controller
`timescale 1ns/100ps
`default_nettype none

module cmo_handler
    import cmo_pkg::*;
#(
    parameter int unsigned NumSets        = 64,
    parameter int unsigned FlushFifoDepth = 3
) (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,

    input  wire logic           req_valid_i,
    output logic                req_ready_o,
    input  wire cmo_req_t       req_i,
    output logic                req_wait_o,

    input  wire cmo_status_t    status_i,

    output logic                wbuf_flush_all_o,

    output logic                dir_check_nline_o,
    output cmo_nline_t          dir_check_nline_o_set_tag_o,
    input  wire cmo_way_vec_t   dir_nline_hit_way_i,

    output logic                dir_check_entry_o,
    output dir_inval_t          dir_entry_sel_o,
    input  wire dir_entry_rsp_t dir_entry_rsp_i,

    output logic                dir_inval_o,
    output dir_inval_t          dir_inval_sel_o,

    output logic                flush_alloc_o,
    output flush_req_t          flush_alloc_req_o,
    input  wire logic           flush_alloc_ready_i
);

    cmo_set_t     walk_set;
    cmo_way_vec_t walk_way;
    logic         walk_set_last;
    logic         walk_way_last;
    logic         walk_reset;
    logic [1:0]   walk_step;

    logic         fifo_w;
    logic         fifo_wok;
    flush_req_t   fifo_wdata;

    cmo_ctrl_fsm #(
        .NumSets (NumSets)
    ) u_ctrl (
        .clk_i                       (clk_i),
        .rst_ni                      (rst_ni),
        .req_valid_i                 (req_valid_i),
        .req_i                       (req_i),
        .status_i                    (status_i),
        .dir_nline_hit_way_i         (dir_nline_hit_way_i),
        .dir_entry_rsp_i             (dir_entry_rsp_i),
        .set_i                       (walk_set),
        .way_i                       (walk_way),
        .set_last_i                  (walk_set_last),
        .way_last_i                  (walk_way_last),
        .fifo_wok_i                  (fifo_wok),
        .fifo_rok_i                  (flush_alloc_o),
        .req_ready_o                 (req_ready_o),
        .req_wait_o                  (req_wait_o),
        .wbuf_flush_all_o            (wbuf_flush_all_o),
        .dir_check_nline_o           (dir_check_nline_o),
        .dir_check_nline_o_set_tag_o (dir_check_nline_o_set_tag_o),
        .dir_check_entry_o           (dir_check_entry_o),
        .dir_entry_sel_o             (dir_entry_sel_o),
        .dir_inval_o                 (dir_inval_o),
        .dir_inval_sel_o             (dir_inval_sel_o),
        .walk_reset_o                (walk_reset),
        .walk_step_o                 (walk_step),
        .fifo_w_o                    (fifo_w),
        .fifo_wdata_o                (fifo_wdata)
    );

    // Bit 1 of the step strobe advances the set, bit 0 the way
    cmo_set_way_walker #(
        .NumSets (NumSets)
    ) u_walker (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .reset_i    (walk_reset),
        .step_set_i (walk_step[1]),
        .step_way_i (walk_step[0]),
        .set_o      (walk_set),
        .way_o      (walk_way),
        .set_last_o (walk_set_last),
        .way_last_o (walk_way_last)
    );

    cmo_flush_fifo #(
        .FlushFifoDepth (FlushFifoDepth)
    ) u_flush_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (fifo_w),
        .wok_o   (fifo_wok),
        .wdata_i (fifo_wdata),
        .r_i     (flush_alloc_ready_i),
        .rok_o   (flush_alloc_o),
        .rdata_o (flush_alloc_req_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_dir_model.sv
// Behavioral directory and flush controller
// Random valid, dirty and tag arrays, check responses one cycle after the
// strobe, invalidation on request and a random ready towards the flush queue
`timescale 1ns/100ps
`default_nettype none

module tb_dir_model
    import cmo_pkg::*;
#(
    parameter int unsigned NumSets = 8
) (
    input  wire logic       clk_i,
    input  wire logic       check_nline_i,
    input  wire cmo_nline_t nline_i,
    input  wire logic       check_entry_i,
    input  wire dir_inval_t entry_sel_i,
    input  wire logic       inval_i,
    input  wire dir_inval_t inval_sel_i,
    output cmo_way_vec_t    hit_way_o,
    output dir_entry_rsp_t  entry_rsp_o,
    output logic            flush_ready_o
);

    logic        valid_q [NumSets][CMO_WAYS];
    logic        dirty_q [NumSets][CMO_WAYS];
    cmo_tag_t    tag_q   [NumSets][CMO_WAYS];
    logic [31:0] rnd;

    function automatic logic [31:0] next_rand(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        hit_way_o     = '0;
        entry_rsp_o   = '0;
        flush_ready_o = 1'b0;
        rnd           = 32'hd1d4;
        // About three entries in four are valid, half of them dirty
        for (int s = 0; s < NumSets; s++) begin
            for (int w = 0; w < CMO_WAYS; w++) begin
                rnd = next_rand(rnd);
                valid_q[s][w] = (rnd[31:30] != 2'b00);
                dirty_q[s][w] = rnd[29];
                tag_q[s][w]   = rnd[27:8];
            end
        end
    end

    // Responses last one cycle only
    always @(posedge clk_i) begin
        cmo_way_vec_t   hit;
        dir_entry_rsp_t rsp;
        int             s;
        hit = '0;
        rsp = '0;
        s   = nline_i[CMO_SET_W-1:0];
        for (int w = 0; w < CMO_WAYS; w++) begin
            if (check_nline_i && s < NumSets && valid_q[s][w]
                    && tag_q[s][w] == nline_i[CMO_NLINE_W-1:CMO_SET_W]) begin
                hit[w] = 1'b1;
            end
            if (check_entry_i && entry_sel_i.way[w]) begin
                rsp = '{valid: valid_q[entry_sel_i.set][w], dirty: dirty_q[entry_sel_i.set][w],
                        tag: tag_q[entry_sel_i.set][w]};
            end
            if (inval_i && inval_sel_i.way[w]) begin
                valid_q[inval_sel_i.set][w] <= 1'b0;
            end
        end
        hit_way_o   <= hit;
        entry_rsp_o <= rsp;
    end

    // Flush controller acceptance, changed just after the clock edge
    always @(posedge clk_i) begin
        #1;
        rnd = next_rand(rnd);
        flush_ready_o = rnd[31];
    end

endmodule

`default_nettype wire

//--- testbench/tb_cmo_handler.sv
// Testbench for the cache maintenance operation handler
// Runs fences, line and whole-cache invalidations and flush walks against a
// behavioral directory and compares every invalidation and write-back
// with a reference prediction of the directory contents
`timescale 1ns/100ps
`default_nettype none

module tb_cmo_handler
    import cmo_pkg::*;
();

    localparam int unsigned NumSets   = 8;
    localparam int unsigned WaitLimit = 2000;

    logic           clk;
    logic           rst_n;
    logic           req_valid;
    cmo_req_t       req;
    cmo_status_t    status;
    logic           req_ready;
    logic           req_wait;
    logic           wbuf_flush_all;
    logic           dir_check_nline;
    cmo_nline_t     check_nline;
    cmo_way_vec_t   hit_way;
    logic           dir_check_entry;
    dir_inval_t     entry_sel;
    dir_entry_rsp_t entry_rsp;
    logic           dir_inval;
    dir_inval_t     inval_sel;
    logic           flush_alloc;
    flush_req_t     flush_req;
    logic           flush_ready;

    // Reference view of the directory
    logic       ref_valid [NumSets][CMO_WAYS];
    logic       ref_dirty [NumSets][CMO_WAYS];
    cmo_tag_t   ref_tag   [NumSets][CMO_WAYS];
    dir_inval_t exp_inval [$];
    flush_req_t exp_flush [$];

    int         inval_errors;
    int         flush_errors;
    int         ctrl_errors;
    int         cyc;
    int         n_inval;
    int         first_inval_cyc;
    int         last_inval_cyc;
    logic       forbid_strobe;
    logic       accept_flush;
    cmo_addr_t  addr_a;
    cmo_addr_t  addr_b;

    cmo_handler #(
        .NumSets        (NumSets),
        .FlushFifoDepth (3)
    ) UUT (
        .clk_i                       (clk),
        .rst_ni                      (rst_n),
        .req_valid_i                 (req_valid),
        .req_ready_o                 (req_ready),
        .req_i                       (req),
        .req_wait_o                  (req_wait),
        .status_i                    (status),
        .wbuf_flush_all_o            (wbuf_flush_all),
        .dir_check_nline_o           (dir_check_nline),
        .dir_check_nline_o_set_tag_o (check_nline),
        .dir_nline_hit_way_i         (hit_way),
        .dir_check_entry_o           (dir_check_entry),
        .dir_entry_sel_o             (entry_sel),
        .dir_entry_rsp_i             (entry_rsp),
        .dir_inval_o                 (dir_inval),
        .dir_inval_sel_o             (inval_sel),
        .flush_alloc_o               (flush_alloc),
        .flush_alloc_req_o           (flush_req),
        .flush_alloc_ready_i         (flush_ready)
    );

    tb_dir_model #(
        .NumSets (NumSets)
    ) u_dir_model (
        .clk_i         (clk),
        .check_nline_i (dir_check_nline),
        .nline_i       (check_nline),
        .check_entry_i (dir_check_entry),
        .entry_sel_i   (entry_sel),
        .inval_i       (dir_inval),
        .inval_sel_i   (inval_sel),
        .hit_way_o     (hit_way),
        .entry_rsp_o   (entry_rsp),
        .flush_ready_o (flush_ready)
    );

    always #5 clk = ~clk;

    function automatic cmo_way_vec_t ref_hit_ways(cmo_nline_t nline);
        cmo_way_vec_t hit;
        int           s;
        hit = '0;
        s   = nline[CMO_SET_W-1:0];
        for (int w = 0; w < CMO_WAYS; w++) begin
            if (s < NumSets && ref_valid[s][w]
                    && ref_tag[s][w] == nline[CMO_NLINE_W-1:CMO_SET_W]) begin
                hit[w] = 1'b1;
            end
        end
        return hit;
    endfunction

    // A hit invalidates every matching way of the line's set
    function automatic void ref_inval_line(cmo_addr_t addr);
        cmo_nline_t   nline;
        dir_inval_t   ev;
        nline  = addr[CMO_OFFSET_W +: CMO_NLINE_W];
        ev.set = nline[CMO_SET_W-1:0];
        ev.way = ref_hit_ways(nline);
        if (ev.way != '0) begin
            exp_inval.push_back(ev);
            for (int w = 0; w < CMO_WAYS; w++) begin
                if (ev.way[w]) begin
                    ref_valid[ev.set][w] = 1'b0;
                end
            end
        end
    endfunction

    function automatic void ref_inval_all();
        dir_inval_t ev;
        for (int s = 0; s < NumSets; s++) begin
            ev = '{set: cmo_set_t'(s), way: '1};
            exp_inval.push_back(ev);
            for (int w = 0; w < CMO_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endfunction

    // Set-then-way walk, write-back of valid dirty entries
    function automatic void ref_flush_all(logic with_inval);
        flush_req_t fr;
        dir_inval_t ev;
        for (int s = 0; s < NumSets; s++) begin
            for (int w = 0; w < CMO_WAYS; w++) begin
                if (ref_valid[s][w] && ref_dirty[s][w]) begin
                    fr = '{nline: {ref_tag[s][w], cmo_set_t'(s)}, way: cmo_way_vec_t'(1) << w};
                    exp_flush.push_back(fr);
                end
                if (with_inval) begin
                    ev = '{set: cmo_set_t'(s), way: cmo_way_vec_t'(1) << w};
                    exp_inval.push_back(ev);
                    ref_valid[s][w] = 1'b0;
                end
            end
        end
    endfunction

    // First valid line at or after a given set, with a nonzero offset
    function automatic cmo_addr_t pick_line(int start_set);
        int s;
        for (int i = 0; i < NumSets; i++) begin
            s = (start_set + i) % NumSets;
            for (int w = 0; w < CMO_WAYS; w++) begin
                if (ref_valid[s][w]) begin
                    return {ref_tag[s][w], cmo_set_t'(s), 6'h15};
                end
            end
        end
        return {20'h0, cmo_set_t'(start_set), 6'h15};
    endfunction

    task automatic check_inval(input dir_inval_t act, input dir_inval_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t: invalidation set %0d way %b, expected set %0d way %b",
                     $time, act.set, act.way, exp.set, exp.way);
            inval_errors++;
        end
    endtask

    task automatic check_flush(input flush_req_t act, input flush_req_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t: write-back line %h way %b, expected line %h way %b",
                     $time, act.nline, act.way, exp.nline, exp.way);
            flush_errors++;
        end
    endtask

    task automatic check_level(input string what, input logic act, input logic exp);
        if (act !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, act, exp);
            ctrl_errors++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < WaitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            abort_run("Timeout while waiting for the handler to return to idle");
        end
    endtask

    // Called while idle, one cycle with the request offered
    task automatic send_req(input cmo_op_e op, input cmo_addr_t addr);
        step();
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        @(negedge clk);
        check_level("req_ready_o on request", req_ready, 1'b1);
        accept_flush = wbuf_flush_all;
        step();
        req_valid = 1'b0;
    endtask

    task automatic finish_op();
        wait_idle();
        if (exp_inval.size() != 0) begin
            $display("Missing %0d expected invalidations at %0t", exp_inval.size(), $time);
            ctrl_errors++;
            exp_inval.delete();
        end
        if (exp_flush.size() != 0) begin
            $display("Missing %0d expected write-backs at %0t", exp_flush.size(), $time);
            ctrl_errors++;
            exp_flush.delete();
        end
    endtask

    // Every directory invalidation and flush transfer against the prediction
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rst_n) begin
            if (forbid_strobe && (dir_check_nline || dir_check_entry || dir_inval)) begin
                $display("Directory strobe at %0t before the cache drained", $time);
                ctrl_errors++;
            end
            if (dir_inval) begin
                if (n_inval == 0) begin
                    first_inval_cyc = cyc;
                end
                last_inval_cyc = cyc;
                n_inval++;
                if (exp_inval.size() == 0) begin
                    $display("Unexpected invalidation of set %0d at %0t", inval_sel.set, $time);
                    ctrl_errors++;
                end else begin
                    check_inval(inval_sel, exp_inval.pop_front());
                end
            end
            if (flush_alloc && flush_ready) begin
                if (exp_flush.size() == 0) begin
                    $display("Unexpected write-back of line %h at %0t", flush_req.nline, $time);
                    ctrl_errors++;
                end else begin
                    check_flush(flush_req, exp_flush.pop_front());
                end
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        status        = '1;
        inval_errors  = 0;
        flush_errors  = 0;
        ctrl_errors   = 0;
        cyc           = 0;
        n_inval       = 0;
        forbid_strobe = 1'b0;
        accept_flush  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int s = 0; s < NumSets; s++) begin
            for (int w = 0; w < CMO_WAYS; w++) begin
                ref_valid[s][w] = u_dir_model.valid_q[s][w];
                ref_dirty[s][w] = u_dir_model.dirty_q[s][w];
                ref_tag[s][w]   = u_dir_model.tag_q[s][w];
            end
        end

        // Idle outputs after reset
        @(negedge clk);
        check_level("req_ready_o after reset", req_ready, 1'b1);
        check_level("req_wait_o after reset", req_wait, 1'b0);
        check_level("wbuf_flush_all_o after reset", wbuf_flush_all, 1'b0);
        check_level("dir_check_nline_o after reset", dir_check_nline, 1'b0);
        check_level("dir_check_entry_o after reset", dir_check_entry, 1'b0);
        check_level("dir_inval_o after reset", dir_inval, 1'b0);
        check_level("flush_alloc_o after reset", flush_alloc, 1'b0);

        // Fence with a busy write buffer
        step();
        status.wbuf_empty = 1'b0;
        send_req(CMO_FENCE, '0);
        check_level("wbuf_flush_all_o on fence accept", accept_flush, 1'b1);
        repeat (4) begin
            @(negedge clk);
            check_level("req_wait_o during fence", req_wait, 1'b1);
            check_level("wbuf_flush_all_o during fence", wbuf_flush_all, 1'b1);
            check_level("req_ready_o during fence", req_ready, 1'b0);
        end
        step();
        status.wbuf_empty = 1'b1;
        finish_op();

        // Line invalidation held back by a busy MSHR
        addr_a = pick_line(3);
        step();
        status.mshr_empty = 1'b0;
        forbid_strobe = 1'b1;
        ref_inval_line(addr_a);
        send_req(CMO_INVAL_NLINE, addr_a);
        repeat (3) begin
            @(negedge clk);
            check_level("req_wait_o while MSHR busy", req_wait, 1'b1);
        end
        step();
        status.mshr_empty = 1'b1;
        forbid_strobe = 1'b0;
        finish_op();

        // Line that is not present
        addr_b = addr_a ^ {20'hfffff, 12'h0};
        ref_inval_line(addr_b);
        send_req(CMO_INVAL_NLINE, addr_b);
        finish_op();

        ref_flush_all(1'b0);
        send_req(CMO_FLUSH_ALL, '0);
        finish_op();

        // Flush and invalidate, then a former line must miss
        addr_a = pick_line(5);
        ref_flush_all(1'b1);
        send_req(CMO_FLUSH_INVAL_ALL, '0);
        finish_op();
        ref_inval_line(addr_a);
        send_req(CMO_INVAL_NLINE, addr_a);
        finish_op();

        n_inval = 0;
        ref_inval_all();
        send_req(CMO_INVAL_ALL, '0);
        finish_op();
        if (n_inval != NumSets || last_inval_cyc - first_inval_cyc != NumSets - 1) begin
            $display("Invalidate all gave %0d strobes over %0d cycles, not %0d in a row",
                     n_inval, last_inval_cyc - first_inval_cyc + 1, NumSets);
            ctrl_errors++;
        end

        step();
        $display("Errors: %0d invalidation, %0d write-back, %0d control",
                 inval_errors, flush_errors, ctrl_errors);
        if (inval_errors + flush_errors + ctrl_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/cmo_pkg.sv
verilog/cmo_set_way_walker.sv
verilog/cmo_flush_fifo.sv
verilog/cmo_ctrl_fsm.sv
verilog/cmo_handler.sv
testbench/tb_dir_model.sv
testbench/tb_cmo_handler.sv
